// File: src/serial_alu_pkg.sv
package serial_alu_pkg;

   // Default word width of the subsystem
   localparam int DATA_WIDTH = 32;

   // Shift amounts are five bits wide whatever the word width
   localparam int SHAMT_WIDTH = 5;

   // Selects which serial result is driven onto the rd stream
   typedef enum logic [1:0] {
      ALU_RESULT_ADD  = 2'd0, // Sum or difference
      ALU_RESULT_SR   = 2'd1, // Shifter output
      ALU_RESULT_LT   = 2'd2, // Set-less-than, only bit 0 can be set
      ALU_RESULT_BOOL = 2'd3  // Bitwise boolean
   } rd_sel_e;

   // Boolean operation codes
   // The values index the 16-entry lookup table in the ALU, four entries per code
   typedef enum logic [1:0] {
      BOOL_AND  = 2'd3,
      BOOL_OR   = 2'd2,
      BOOL_XNOR = 2'd1, // Bitwise equality
      BOOL_XOR  = 2'd0
   } bool_op_e;

endpackage

// File: src/serial_adder.sv
module serial_adder (
   input  logic clk,
   input  logic i_reset,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q,
   output logic o_carry
);

   logic carry_q;

   assign o_q     = i_a ^ i_b ^ carry_q;
   // Carry out of the current bit, becomes the carry in of the next one
   assign o_carry = (i_a & i_b) | (i_a & carry_q) | (i_b & carry_q);

   always_ff @(posedge clk) begin
      if (i_reset || i_clr) begin
         carry_q <= 1'b0;
      end else begin
         carry_q <= o_carry;
      end
   end

endmodule

// File: src/serial_less_than.sv
module serial_less_than (
   input  logic clk,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   input  logic i_sign,
   output logic o_lt
);

   logic lt_q; // Result over the bits seen so far

   // A higher differing bit overrides whatever the lower bits decided
   always_comb begin
      if (i_a == i_b) begin
         o_lt = lt_q;
      end else if (i_sign) begin
         o_lt = i_a; // Top bit of a signed word, a set bit means negative
      end else begin
         o_lt = i_b;
      end
   end

   always_ff @(posedge clk) begin
      if (i_clr) begin
         lt_q <= 1'b0;
      end else begin
         lt_q <= o_lt;
      end
   end

endmodule

// File: src/serial_shifter.sv
module serial_shifter #(
   parameter int W = serial_alu_pkg::DATA_WIDTH
) (
   input  logic                                  clk,
   input  logic                                  i_load,
   input  logic [serial_alu_pkg::SHAMT_WIDTH-1:0] i_shamt,
   input  logic                                  i_shamt_msb,
   input  logic                                  i_signbit,
   input  logic                                  i_right,
   input  logic                                  i_d,
   output logic                                  o_done,
   output logic                                  o_q
);

   import serial_alu_pkg::*;

   localparam int CW = $clog2(W);
   localparam int JW = SHAMT_WIDTH + 1;

   logic [W-1:0]  data;
   logic [W-1:0]  word;
   logic          load_r;
   logic          signbit_r;
   logic          replay;
   logic [CW-1:0] cnt;      // Output bit index during replay
   logic [JW-1:0] pos;
   logic [CW-1:0] idx;
   logic          in_range;

   always_ff @(posedge clk) begin
      load_r <= i_load;
      // One extra shift after load picks up the last bit of the delayed stream
      if (i_load || load_r) begin
         data <= {i_d, data[W-1:1]};
      end
      if (i_load) begin
         signbit_r <= i_signbit;
      end
      cnt    <= i_load ? '0 : cnt + 1'b1;
      replay <= i_load | (replay & ~o_done);
   end

   // In the first replay cycle the top bit is still on i_d
   assign word = load_r ? {i_d, data[W-1:1]} : data;

   // Right shifts read bit cnt+shamt. Left shifts add the negated amount,
   // so a carry into the top bit of pos means cnt >= shamt
   assign pos = JW'(cnt) + {~i_right & i_shamt_msb, i_shamt};
   assign idx = pos[CW-1:0];

   assign in_range = i_right ? (pos < JW'(W)) : pos[JW-1];

   assign o_q = in_range ? word[idx] : (i_right & signbit_r);

   assign o_done = replay & ~i_load & (cnt == CW'(W - 1));

endmodule

// File: src/serial_alu.sv
module serial_alu #(
   parameter int W = serial_alu_pkg::DATA_WIDTH
) (
   input  logic       clk,
   input  logic       i_reset,
   input  logic       i_en,
   input  logic       i_rs1,
   input  logic       i_rs2,
   input  logic       i_imm,
   input  logic       i_op_b_rs2,
   input  logic       i_buf,
   input  logic       i_init,
   input  logic       i_cnt_done,
   input  logic       i_sub,
   input  logic [1:0] i_bool_op,
   input  logic       i_cmp_eq,
   input  logic       i_cmp_uns,
   output logic       o_cmp,
   input  logic       i_shamt_en,
   input  logic       i_sh_right,
   input  logic       i_sh_signed,
   output logic       o_sh_done,
   input  logic [1:0] i_rd_sel,
   output logic       o_rd
);

   import serial_alu_pkg::*;

   // XOR, XNOR, OR and AND from the lowest nibble up
   localparam logic [15:0] BOOL_LUT = 16'h8E96;

   logic                   op_b;
   logic                   add_b;
   logic                   plus_1;
   logic                   en_r;
   logic                   b_neg;
   logic                   b_neg_cy;
   logic                   result_add;
   logic                   result_lt;
   logic                   result_sh;
   logic                   result_bool;
   logic                   result_eq;
   logic                   lt_r;
   logic                   eq_r;
   logic                   shamt_ser;
   logic [SHAMT_WIDTH-1:0] shamt;
   logic                   shamt_msb;

   assign op_b   = i_op_b_rs2 ? i_rs2 : i_imm;
   assign plus_1 = i_en & ~en_r; // High on bit 0 only

   // Two's complement of operand B, one bit per cycle
   serial_adder u_neg_b (
      .clk     (clk),
      .i_reset (i_reset),
      .i_a     (~op_b),
      .i_b     (plus_1),
      .i_clr   (~i_en),
      .o_q     (b_neg),
      .o_carry (b_neg_cy)
   );

   assign add_b = i_sub ? b_neg : op_b;

   serial_adder u_add (
      .clk     (clk),
      .i_reset (i_reset),
      .i_a     (i_rs1),
      .i_b     (add_b),
      .i_clr   (~i_en),
      .o_q     (result_add),
      .o_carry ()
   );

   serial_less_than u_lt (
      .clk    (clk),
      .i_a    (i_rs1),
      .i_b    (op_b),
      .i_clr  (~i_en),
      .i_sign (i_cnt_done & ~i_cmp_uns),
      .o_lt   (result_lt)
   );

   // Left shifts collect the negated amount, a carry out of bit 4 flags zero
   assign shamt_ser = i_sh_right ? op_b : b_neg;

   always_ff @(posedge clk) begin
      if (i_shamt_en) begin
         shamt     <= {shamt_ser, shamt[SHAMT_WIDTH-1:1]};
         shamt_msb <= b_neg_cy;
      end
   end

   serial_shifter #(.W(W)) u_shifter (
      .clk         (clk),
      .i_load      (i_init),
      .i_shamt     (shamt),
      .i_shamt_msb (shamt_msb),
      .i_signbit   (i_sh_signed & i_rs1),
      .i_right     (i_sh_right),
      .i_d         (i_buf),
      .o_done      (o_sh_done),
      .o_q         (result_sh)
   );

   assign result_bool = BOOL_LUT[{i_bool_op, i_rs1, op_b}];
   assign result_eq   = eq_r & (i_rs1 == op_b);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         en_r <= 1'b0;
      end else begin
         en_r <= i_en;
      end
      if (i_en) begin
         lt_r <= result_lt;
      end
      eq_r <= result_eq | ~i_en;
   end

   // Both flags hold the whole-word answer in the cycle after the last bit
   assign o_cmp = i_cmp_eq ? eq_r : lt_r;

   always_comb begin
      case (i_rd_sel)
         ALU_RESULT_ADD:  o_rd = result_add;
         ALU_RESULT_SR:   o_rd = result_sh;
         ALU_RESULT_LT:   o_rd = result_lt & i_cnt_done; // Known on the last bit only
         ALU_RESULT_BOOL: o_rd = result_bool;
         default:         o_rd = 1'b0;
      endcase
   end

endmodule

// File: src/serial_alu_sequencer.sv
module serial_alu_sequencer #(
   parameter int W = serial_alu_pkg::DATA_WIDTH
) (
   input  logic clk,
   input  logic i_reset,
   input  logic i_start,
   input  logic i_is_shift,
   input  logic i_sh_done,
   output logic o_busy,
   output logic o_load,
   output logic o_en,
   output logic o_init,
   output logic o_cnt_done,
   output logic o_shamt_en,
   output logic o_done
);

   import serial_alu_pkg::*;

   localparam int CW = $clog2(W);

   typedef enum logic [1:0] {
      IDLE,
      PASS1,
      PASS2 // Shifter replay
   } phase_e;

   phase_e        phase;
   logic [CW-1:0] cnt;
   logic          shift_q;
   logic          last_bit;

   assign o_busy     = phase != IDLE;
   assign o_load     = i_start & (phase == IDLE); // Starts while busy are dropped here
   assign o_en       = o_busy;
   assign last_bit   = cnt == CW'(W - 1);
   assign o_cnt_done = o_en & last_bit;
   assign o_init     = (phase == PASS1) & shift_q;
   assign o_shamt_en = o_init & (cnt < CW'(SHAMT_WIDTH));

   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase   <= IDLE;
         cnt     <= '0;
         shift_q <= 1'b0;
         o_done  <= 1'b0;
      end else begin
         o_done <= 1'b0;
         case (phase)
            IDLE: begin
               if (i_start) begin
                  phase   <= PASS1;
                  cnt     <= '0;
                  shift_q <= i_is_shift;
               end
            end
            PASS1: begin
               cnt <= cnt + 1'b1;
               if (last_bit) begin
                  if (shift_q) begin
                     phase <= PASS2;
                  end else begin
                     phase  <= IDLE;
                     o_done <= 1'b1;
                  end
               end
            end
            PASS2: begin
               cnt <= cnt + 1'b1;
               if (i_sh_done) begin
                  phase  <= IDLE;
                  o_done <= 1'b1;
               end
            end
            default: phase <= IDLE;
         endcase
      end
   end

endmodule

// File: src/operand_serdes.sv
module operand_serdes #(
   parameter int W = serial_alu_pkg::DATA_WIDTH
) (
   input  logic         clk,
   input  logic         i_reset,
   input  logic         i_load,
   input  logic         i_shift_en,
   input  logic [W-1:0] i_rs1_word,
   input  logic [W-1:0] i_rs2_word,
   input  logic [W-1:0] i_imm_word,
   input  logic         i_rd,
   input  logic         i_done,
   input  logic         i_op_b_rs2,
   input  logic         i_sub,
   input  logic [1:0]   i_bool_op,
   input  logic         i_cmp_eq,
   input  logic         i_cmp_uns,
   input  logic         i_sh_right,
   input  logic         i_sh_signed,
   input  logic [1:0]   i_rd_sel,
   output logic         o_rs1,
   output logic         o_rs2,
   output logic         o_imm,
   output logic         o_buf,
   output logic         o_op_b_rs2,
   output logic         o_sub,
   output logic [1:0]   o_bool_op,
   output logic         o_cmp_eq,
   output logic         o_cmp_uns,
   output logic         o_sh_right,
   output logic         o_sh_signed,
   output logic [1:0]   o_rd_sel,
   output logic [W-1:0] o_result_word
);

   import serial_alu_pkg::*;

   logic [W-1:0] rs1_q;
   logic [W-1:0] rs2_q;
   logic [W-1:0] imm_q;
   logic [W-1:0] result_q;

   always_ff @(posedge clk) begin
      if (i_load) begin
         rs1_q <= i_rs1_word;
         rs2_q <= i_rs2_word;
         imm_q <= i_imm_word;
         o_buf <= 1'b0;
      end else if (i_shift_en) begin
         rs1_q <= {1'b0, rs1_q[W-1:1]};
         rs2_q <= {1'b0, rs2_q[W-1:1]};
         imm_q <= {1'b0, imm_q[W-1:1]};
         o_buf <= rs1_q[0]; // rs1 one bit late
      end
      // A second pass overwrites the bits of the first
      if (i_shift_en) begin
         result_q <= {i_rd, result_q[W-1:1]};
      end
   end

   // Operation fields stay put for the whole operation
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_op_b_rs2  <= 1'b0;
         o_sub       <= 1'b0;
         o_bool_op   <= 2'b00;
         o_cmp_eq    <= 1'b0;
         o_cmp_uns   <= 1'b0;
         o_sh_right  <= 1'b0;
         o_sh_signed <= 1'b0;
         o_rd_sel    <= 2'b00;
      end else if (i_load) begin
         o_op_b_rs2  <= i_op_b_rs2;
         o_sub       <= i_sub;
         o_bool_op   <= i_bool_op;
         o_cmp_eq    <= i_cmp_eq;
         o_cmp_uns   <= i_cmp_uns;
         o_sh_right  <= i_sh_right;
         o_sh_signed <= i_sh_signed;
         o_rd_sel    <= i_rd_sel;
      end else if (i_done) begin
         o_sh_right  <= 1'b0;
         o_sh_signed <= 1'b0;
         o_rd_sel    <= 2'b00;
      end
   end

   assign o_rs1 = rs1_q[0];
   assign o_rs2 = rs2_q[0];
   assign o_imm = imm_q[0];

   // The less-than bit arrives last and lands in the top position, move it to bit 0
   assign o_result_word = (o_rd_sel == ALU_RESULT_LT) ? {{(W-1){1'b0}}, result_q[W-1]}
                                                      : result_q;

endmodule

// File: src/serial_alu_top.sv
module serial_alu_top #(
   parameter int W = serial_alu_pkg::DATA_WIDTH
) (
   input  logic         clk,
   input  logic         i_reset,
   input  logic         i_start,
   input  logic [W-1:0] i_rs1_word,
   input  logic [W-1:0] i_rs2_word,
   input  logic [W-1:0] i_imm_word,
   input  logic         i_op_b_rs2,
   input  logic         i_sub,
   input  logic [1:0]   i_bool_op,
   input  logic         i_cmp_eq,
   input  logic         i_cmp_uns,
   input  logic         i_sh_right,
   input  logic         i_sh_signed,
   input  logic         i_is_shift,
   input  logic [1:0]   i_rd_sel,
   output logic         o_busy,
   output logic         o_done,
   output logic [W-1:0] o_result_word,
   output logic         o_cmp
);

   logic       load;
   logic       en;
   logic       init;
   logic       cnt_done;
   logic       shamt_en;
   logic       sh_done;
   logic       rs1;
   logic       rs2;
   logic       imm;
   logic       buf_bit;
   logic       rd;
   logic       op_b_rs2_q;
   logic       sub_q;
   logic [1:0] bool_op_q;
   logic       cmp_eq_q;
   logic       cmp_uns_q;
   logic       sh_right_q;
   logic       sh_signed_q;
   logic [1:0] rd_sel_q;

   serial_alu_sequencer #(.W(W)) u_sequencer (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_start    (i_start),
      .i_is_shift (i_is_shift),
      .i_sh_done  (sh_done),
      .o_busy     (o_busy),
      .o_load     (load),
      .o_en       (en),
      .o_init     (init),
      .o_cnt_done (cnt_done),
      .o_shamt_en (shamt_en),
      .o_done     (o_done)
   );

   operand_serdes #(.W(W)) u_serdes (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_load        (load),
      .i_shift_en    (en),
      .i_rs1_word    (i_rs1_word),
      .i_rs2_word    (i_rs2_word),
      .i_imm_word    (i_imm_word),
      .i_rd          (rd),
      .i_done        (o_done),
      .i_op_b_rs2    (i_op_b_rs2),
      .i_sub         (i_sub),
      .i_bool_op     (i_bool_op),
      .i_cmp_eq      (i_cmp_eq),
      .i_cmp_uns     (i_cmp_uns),
      .i_sh_right    (i_sh_right),
      .i_sh_signed   (i_sh_signed),
      .i_rd_sel      (i_rd_sel),
      .o_rs1         (rs1),
      .o_rs2         (rs2),
      .o_imm         (imm),
      .o_buf         (buf_bit),
      .o_op_b_rs2    (op_b_rs2_q),
      .o_sub         (sub_q),
      .o_bool_op     (bool_op_q),
      .o_cmp_eq      (cmp_eq_q),
      .o_cmp_uns     (cmp_uns_q),
      .o_sh_right    (sh_right_q),
      .o_sh_signed   (sh_signed_q),
      .o_rd_sel      (rd_sel_q),
      .o_result_word (o_result_word)
   );

   serial_alu #(.W(W)) u_alu (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_en        (en),
      .i_rs1       (rs1),
      .i_rs2       (rs2),
      .i_imm       (imm),
      .i_op_b_rs2  (op_b_rs2_q),
      .i_buf       (buf_bit),
      .i_init      (init),
      .i_cnt_done  (cnt_done),
      .i_sub       (sub_q),
      .i_bool_op   (bool_op_q),
      .i_cmp_eq    (cmp_eq_q),
      .i_cmp_uns   (cmp_uns_q),
      .o_cmp       (o_cmp),
      .i_shamt_en  (shamt_en),
      .i_sh_right  (sh_right_q),
      .i_sh_signed (sh_signed_q),
      .o_sh_done   (sh_done),
      .i_rd_sel    (rd_sel_q),
      .o_rd        (rd)
   );

endmodule

// File: verification/serial_alu_checker.sv
module serial_alu_checker #(
   parameter int W = serial_alu_pkg::DATA_WIDTH
) (
   input  logic         clk,
   input  logic         i_reset,
   input  logic         i_start,
   input  logic [W-1:0] i_rs1_word,
   input  logic [W-1:0] i_rs2_word,
   input  logic [W-1:0] i_imm_word,
   input  logic         i_op_b_rs2,
   input  logic         i_sub,
   input  logic [1:0]   i_bool_op,
   input  logic         i_cmp_eq,
   input  logic         i_cmp_uns,
   input  logic         i_sh_right,
   input  logic         i_sh_signed,
   input  logic         i_is_shift,
   input  logic [1:0]   i_rd_sel,
   input  logic         i_busy,
   input  logic         i_done,
   input  logic [W-1:0] i_result_word,
   input  logic         i_cmp,
   input  logic         i_exp_valid,
   input  logic [W-1:0] i_exp_result,
   input  logic         i_exp_cmp,
   output int           o_tests,
   output int           o_failed,
   output int           o_errors
);

   import serial_alu_pkg::*;

   logic         pending;
   logic         busy_ok;
   int           lat;
   logic [W-1:0] exp_result;
   logic         exp_cmp;
   logic         chk_result;
   logic         chk_cmp;
   logic         shift_op;

   // Reference model of the ALU, written from the operation rules
   function automatic logic [W-1:0] model_result(input logic [W-1:0] a, input logic [W-1:0] b);
      logic lt;
      lt = i_cmp_uns ? (a < b) : ($signed(a) < $signed(b));
      if (i_is_shift) begin
         if (!i_sh_right) return a << b[4:0];
         if (i_sh_signed) return $signed(a) >>> b[4:0];
         return a >> b[4:0];
      end
      case (i_rd_sel)
         ALU_RESULT_ADD:  return i_sub ? a - b : a + b;
         ALU_RESULT_LT:   return {{(W-1){1'b0}}, lt};
         ALU_RESULT_BOOL: begin
            case (i_bool_op)
               BOOL_AND:  return a & b;
               BOOL_OR:   return a | b;
               BOOL_XNOR: return ~(a ^ b);
               default:   return a ^ b;
            endcase
         end
         default: return '0;
      endcase
   endfunction

   function automatic logic model_cmp(input logic [W-1:0] a, input logic [W-1:0] b);
      if (i_cmp_eq) return a == b;
      return i_cmp_uns ? (a < b) : ($signed(a) < $signed(b));
   endfunction

   initial begin
      pending  = 1'b0;
      busy_ok  = 1'b1;
      o_tests  = 0;
      o_failed = 0;
      o_errors = 0;
   end

   // Sampling on the edge sees the values held during the cycle before it
   always @(posedge clk) begin
      logic         ok;
      logic         exp_busy;
      logic [W-1:0] op_b;
      int           exp_lat;
      ok = 1'b1;
      exp_busy = pending && !i_done; // Busy from the cycle after start up to done
      op_b = i_op_b_rs2 ? i_rs2_word : i_imm_word;
      exp_lat = shift_op ? 2 * W + 1 : W + 1;
      if (i_reset) begin
         pending = 1'b0;
      end else begin
         if (i_busy !== exp_busy) begin
            $display("** Error at time %0t: o_busy = %b, expected %b",
                     $time, i_busy, exp_busy);
            if (pending) begin
               busy_ok = 1'b0;
            end else begin
               o_errors++;
            end
         end
         if (i_done) begin
            if (!pending) begin
               o_errors++;
               $display("o_done pulsed at time %0t with no operation in flight", $time);
            end else begin
               if (chk_result && i_result_word !== exp_result) begin
                  ok = 1'b0;
                  $display("** Error at time %0t: o_result_word = 0x%h, expected 0x%h",
                           $time, i_result_word, exp_result);
               end
               if (chk_cmp && i_cmp !== exp_cmp) begin
                  ok = 1'b0;
                  $display("** Error at time %0t: o_cmp = %b, expected %b",
                           $time, i_cmp, exp_cmp);
               end
               if (lat != exp_lat) begin
                  ok = 1'b0;
                  $display("Operation finished %0d cycles after start instead of %0d",
                           lat, exp_lat);
               end
               if (!busy_ok) begin
                  ok = 1'b0;
               end
               o_tests++;
               if (!ok) begin
                  o_failed++;
                  o_errors++;
               end
               $display("test %0d: %s", o_tests, ok ? "ok" : "FAILED");
               pending = 1'b0;
            end
         end else if (pending) begin
            lat++;
         end
         // A start during an operation is ignored
         if (i_start && !pending) begin
            pending    = 1'b1;
            busy_ok    = 1'b1;
            lat        = 1;
            shift_op   = i_is_shift;
            chk_result = !i_cmp_eq; // Branch compares only produce the flag
            chk_cmp    = i_cmp_eq || (i_rd_sel == ALU_RESULT_LT && !i_is_shift);
            exp_result = i_exp_valid ? i_exp_result : model_result(i_rs1_word, op_b);
            exp_cmp    = i_exp_valid ? i_exp_cmp : model_cmp(i_rs1_word, op_b);
         end
      end
   end

endmodule

// File: verification/serial_alu_sva.sv
module serial_alu_sva #(
   parameter int W  = serial_alu_pkg::DATA_WIDTH,
   parameter int CW = $clog2(W)
) (
   input logic          clk,
   input logic          i_reset,
   input logic          i_start,
   input logic          o_busy,
   input logic          o_load,
   input logic          o_en,
   input logic          o_done,
   input logic [CW-1:0] cnt
);

   logic idle; // From reset or done until the next load

   always_ff @(posedge clk) begin
      if (i_reset) begin
         idle <= 1'b1;
      end else if (o_load) begin
         idle <= 1'b0;
      end else if (o_done) begin
         idle <= 1'b1;
      end
   end

   a_done_pulse: assert property (@(posedge clk) disable iff (i_reset) o_done |=> !o_done)
      else $error("o_done stayed high for more than one cycle");

   // A start during an operation leaves the bit counter running
   a_start_busy_cnt: assert property (@(posedge clk) disable iff (i_reset)
      (o_busy && i_start) |=> cnt == CW'($past(cnt) + 1'b1))
      else $error("start while busy disturbed the bit counter");

   a_idle_en: assert property (@(posedge clk) disable iff (i_reset)
      (idle || o_done) |-> !o_en)
      else $error("en high while idle");

endmodule

bind serial_alu_sequencer serial_alu_sva #(.W(W)) u_sva (
   .clk     (clk),
   .i_reset (i_reset),
   .i_start (i_start),
   .o_busy  (o_busy),
   .o_load  (o_load),
   .o_en    (o_en),
   .o_done  (o_done),
   .cnt     (cnt)
);

// File: verification/tb_serial_alu.sv
module tb_serial_alu;

   import serial_alu_pkg::*;

   localparam int W      = DATA_WIDTH;
   localparam int N_RAND = 40;

   logic         clk;
   logic         i_reset;
   logic         i_start;
   logic [W-1:0] i_rs1_word;
   logic [W-1:0] i_rs2_word;
   logic [W-1:0] i_imm_word;
   logic         i_op_b_rs2;
   logic         i_sub;
   logic [1:0]   i_bool_op;
   logic         i_cmp_eq;
   logic         i_cmp_uns;
   logic         i_sh_right;
   logic         i_sh_signed;
   logic         i_is_shift;
   logic [1:0]   i_rd_sel;
   logic         o_busy;
   logic         o_done;
   logic [W-1:0] o_result_word;
   logic         o_cmp;
   logic         exp_valid;
   logic [W-1:0] exp_result;
   logic         exp_cmp;
   int           n_tests;
   int           n_failed;
   int           n_errors;

   // Control codes: add, addi, sub, slt, sltu, eq, and, or, xnor, xor, sll, srl, sra
   logic [11:0] op_codes [13] = '{12'h001, 12'h000, 12'h003, 12'h401, 12'h421, 12'h011,
                                  12'h60D, 12'h609, 12'h605, 12'h601, 12'h301, 12'h341,
                                  12'h3C1};

   logic [11:0]  file_ctrl [$];
   logic [W-1:0] file_rs1 [$];
   logic [W-1:0] file_rs2 [$];
   logic [W-1:0] file_imm [$];
   logic [W-1:0] file_res [$];
   logic         file_cmp [$];

   serial_alu_top #(.W(W)) i_dut (.*);

   serial_alu_checker #(.W(W)) u_checker (
      .clk (clk), .i_reset (i_reset), .i_start (i_start),
      .i_rs1_word (i_rs1_word), .i_rs2_word (i_rs2_word), .i_imm_word (i_imm_word),
      .i_op_b_rs2 (i_op_b_rs2), .i_sub (i_sub), .i_bool_op (i_bool_op),
      .i_cmp_eq (i_cmp_eq), .i_cmp_uns (i_cmp_uns), .i_sh_right (i_sh_right),
      .i_sh_signed (i_sh_signed), .i_is_shift (i_is_shift), .i_rd_sel (i_rd_sel),
      .i_busy (o_busy), .i_done (o_done), .i_result_word (o_result_word), .i_cmp (o_cmp),
      .i_exp_valid (exp_valid), .i_exp_result (exp_result), .i_exp_cmp (exp_cmp),
      .o_tests (n_tests), .o_failed (n_failed), .o_errors (n_errors)
   );

   always #4 clk = ~clk;

   task automatic read_testdata();
      int           fd;
      string        line;
      logic [11:0]  c;
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic [W-1:0] m;
      logic [W-1:0] r;
      logic [3:0]   q;
      fd = $fopen("verification/serial_alu_testdata.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the test data file");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() == 0 || line[0] == 8'h23) continue; // Comment or empty line
         if ($sscanf(line, "%h %h %h %h %h %h", c, a, b, m, r, q) == 6) begin
            file_ctrl.push_back(c);
            file_rs1.push_back(a);
            file_rs2.push_back(b);
            file_imm.push_back(m);
            file_res.push_back(r);
            file_cmp.push_back(q[0]);
         end
      end
      $fclose(fd);
   endtask

   task automatic run_op(input logic [11:0] ctrl, input logic [W-1:0] rs1,
                         input logic [W-1:0] rs2, input logic [W-1:0] imm,
                         input logic from_file, input logic [W-1:0] exp_r,
                         input logic exp_c, input logic poke_busy);
      @(posedge clk);
      i_start     <= 1'b1;
      i_rs1_word  <= rs1;
      i_rs2_word  <= rs2;
      i_imm_word  <= imm;
      i_op_b_rs2  <= ctrl[0];
      i_sub       <= ctrl[1];
      i_bool_op   <= ctrl[3:2];
      i_cmp_eq    <= ctrl[4];
      i_cmp_uns   <= ctrl[5];
      i_sh_right  <= ctrl[6];
      i_sh_signed <= ctrl[7];
      i_is_shift  <= ctrl[8];
      i_rd_sel    <= ctrl[10:9];
      exp_valid   <= from_file;
      exp_result  <= exp_r;
      exp_cmp     <= exp_c;
      @(posedge clk);
      i_start <= 1'b0;
      if (poke_busy) begin
         repeat (3) @(posedge clk);
         i_start    <= 1'b1; // Must be ignored while busy
         i_rs1_word <= ~rs1;
         i_rs2_word <= ~rs2;
         i_is_shift <= ~ctrl[8];
         @(posedge clk);
         i_start <= 1'b0;
      end
      do @(negedge clk); while (!o_done);
   endtask

   initial begin
      int          seed;
      int          total;
      logic [11:0] ctrl;
      logic [W-1:0] a;
      logic [W-1:0] b;
      clk         = 1'b0;
      i_reset     = 1'b1;
      i_start     = 1'b0;
      i_rs1_word  = '0;
      i_rs2_word  = '0;
      i_imm_word  = '0;
      i_op_b_rs2  = 1'b0;
      i_sub       = 1'b0;
      i_bool_op   = 2'b00;
      i_cmp_eq    = 1'b0;
      i_cmp_uns   = 1'b0;
      i_sh_right  = 1'b0;
      i_sh_signed = 1'b0;
      i_is_shift  = 1'b0;
      i_rd_sel    = 2'b00;
      exp_valid   = 1'b0;
      exp_result  = '0;
      exp_cmp     = 1'b0;
      seed        = 32'h0b4e154e;
      read_testdata();
      total = file_ctrl.size() + N_RAND;
      fork
         begin
            #((total * (2 * W + 4) + 10) * 8);
            $display("Watchdog expired before all operations finished");
            $display("tests failed");
            $finish;
         end
      join_none
      repeat (2) @(posedge clk);
      i_reset <= 1'b0;
      foreach (file_ctrl[k]) begin
         run_op(file_ctrl[k], file_rs1[k], file_rs2[k], file_imm[k], 1'b1, file_res[k],
                file_cmp[k], 1'b0);
      end
      for (int t = 0; t < N_RAND; t++) begin
         ctrl = op_codes[$unsigned($random(seed)) % 13];
         a = $random(seed);
         b = (t % 5 == 0) ? a : $random(seed); // Equal operands now and then
         if (t % 7 == 3) a = {1'b1, {(W-1){1'b0}}};
         run_op(ctrl, a, b, $random(seed), 1'b0, '0, 1'b0, t % 4 == 1);
      end
      @(posedge clk);
      @(negedge clk);
      $display("%0d tests run, %0d passed, %0d failed, %0d errors",
               n_tests, n_tests - n_failed, n_failed, n_errors);
      if (n_errors == 0 && n_tests == total && file_ctrl.size() != 0) begin
         $display("all tests passed");
      end else begin
         if (file_ctrl.size() == 0) $display("No operations were read from the test data file");
         if (n_tests != total) $display("Only %0d of %0d tests completed", n_tests, total);
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: verification/serial_alu_testdata.txt
# ctrl rs1 rs2 imm result cmp, all hex. ctrl bits: 0 op_b_rs2, 1 sub, 3:2 bool_op,
# 4 cmp_eq, 5 cmp_uns, 6 sh_right, 7 sh_signed, 8 is_shift, 10:9 rd_sel
001 7fffffff 00000001 00000000 80000000 0
001 ffffffff 00000001 00000000 00000000 0
000 ffffffff 00000000 ffffffff fffffffe 0
003 00000000 00000001 00000000 ffffffff 0
003 12345678 12345678 00000000 00000000 0
401 80000000 00000000 00000000 00000001 1
421 80000000 00000000 00000000 00000000 0
401 ffffffff 00000000 00000000 00000001 1
421 00000000 ffffffff 00000000 00000001 1
401 00000000 00000000 00000000 00000000 0
011 deadbeef deadbeef 00000000 00000000 1
011 deadbeef deadbeee 00000000 00000000 0
60D f0f0ff00 0ff00ff0 00000000 00f00f00 0
609 f0f0ff00 0ff00ff0 00000000 fff0fff0 0
601 f0f0ff00 0ff00ff0 00000000 ff00f0f0 0
605 f0f0ff00 0ff00ff0 00000000 00ff0f0f 0
301 00000001 0000001f 00000000 80000000 0
301 a5a5a5a5 00000000 00000000 a5a5a5a5 0
341 80000000 0000001f 00000000 00000001 0
3C1 80000000 0000001f 00000000 ffffffff 0
3C0 f0000000 00000000 00000004 ff000000 0
301 12345678 00000024 00000000 23456780 0
341 f0000000 00000004 00000000 0f000000 0

// File: list.f
src/serial_alu_pkg.sv
src/serial_adder.sv
src/serial_less_than.sv
src/serial_shifter.sv
src/serial_alu.sv
src/serial_alu_sequencer.sv
src/operand_serdes.sv
src/serial_alu_top.sv
verification/serial_alu_checker.sv
verification/serial_alu_sva.sv
verification/tb_serial_alu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module tb_serial_alu -o sim_serial_alu &&
./obj_dir/sim_serial_alu | tee /dev/stderr | grep -qx "all tests passed" &&
echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }
